// ==== stub_reader.f ====
design/stub_pkg.sv
design/io_bus_pkg.sv
design/stub_capture_lane.sv
design/read_address_gen.sv
design/io_readback.sv
design/stub_reader_top.sv
bench/tb_stub_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the stub reader testbench with Verilator, run it, grade the log

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --assert \
    --top-module tb_stub_reader \
    -f stub_reader.f \
    -o tb_stub_reader > "$LOG" 2>&1 \
    && ./obj_dir/tb_stub_reader >> "$LOG" 2>&1

cat "$LOG"

grep -q "^Simulation finished: PASS$" "$LOG" \
    && echo "run_sim.sh: test passed" \
    || { echo "run_sim.sh: test failed"; exit 1; }

// ==== bench/tb_stub_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stub_reader;

    localparam int CLK_PERIOD = 20;                 // ns
    localparam int NUM_ROWS   = 140;                // Table length
    localparam int PHASE_B    = 48;                 // First row with bus reads
    localparam int PHASE_C    = 128;                // First quiet row with counters held
    localparam logic [31:0] SEED = 32'h8f93;

    typedef logic [stub_pkg::NUM_LANES-1:0][stub_pkg::RD_ADDR_W-1:0] lane_cnt_t;

    // One row of the stimulus table
    typedef struct packed {
        logic [3:0]                        lane;    // Lane that gets the word
        stub_pkg::stub_t                   word;    // All zero means no stub
        lane_cnt_t                         cnt;     // stub_count per lane
        logic                              sel;
        logic                              sync;
        logic                              rd_en;
        logic [io_bus_pkg::LANE_SEL_W-1:0] rd_lane;
        stub_pkg::ptr_t                    rd_word;
        io_bus_pkg::io_rsp_t               exp_rsp; // Due two cycles later
        lane_cnt_t                         exp_addr; // read_addr after this row's edge
    } step_t;

    logic                clk;
    logic                rst_n;
    stub_pkg::stub_t     stub_in    [stub_pkg::NUM_LANES];
    stub_pkg::rd_addr_t  stub_count [stub_pkg::NUM_LANES];
    stub_pkg::rd_addr_t  read_addr  [stub_pkg::NUM_LANES];
    io_bus_pkg::io_req_t io_req;
    io_bus_pkg::io_rsp_t io_rsp;

    step_t               steps [NUM_ROWS];
    io_bus_pkg::io_rsp_t exp_q [$];                 // Two-stage response delay
    logic [31:0]         model_mem  [stub_pkg::NUM_LANES][stub_pkg::BUF_DEPTH];
    int                  model_wptr [stub_pkg::NUM_LANES];   // Stubs stored so far
    stub_pkg::rd_addr_t  model_addr [stub_pkg::NUM_LANES];
    int                  errors;
    int                  checks;

    stub_reader_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .stub_in    (stub_in),
        .stub_count (stub_count),
        .read_addr  (read_addr),
        .io_req     (io_req),
        .io_rsp     (io_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // Response of the row two back and counters of the row before
    task automatic compare_outputs(input lane_cnt_t exp_addr);
        io_bus_pkg::io_rsp_t exp;
        exp = exp_q.pop_front();
        check_value("io_rsp.ack", 64'(exp.ack), 64'(io_rsp.ack));
        if (exp.ack) begin
            check_value("io_rsp.data", 64'(exp.data), 64'(io_rsp.data));
        end
        for (int l = 0; l < stub_pkg::NUM_LANES; l++) begin
            check_value($sformatf("read_addr[%0d]", l), 64'(exp_addr[l]), 64'(read_addr[l]));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and table
    ////////////////////////////////////////////////////////////

    function automatic stub_pkg::stub_t random_stub();
        stub_pkg::stub_t w;
        logic [31:0]     r;
        r         = $urandom_range(1, 15);          // Nonzero tag keeps the word nonzero
        w.tag     = r[stub_pkg::TAG_W-1:0];
        w.payload = $urandom();
        return w;
    endfunction

    task automatic make_stimulus(input int i, output step_t s);
        int          j;
        logic [31:0] r;
        s = '0;
        j = i - PHASE_B;
        if (i < PHASE_B) begin
            r      = i % stub_pkg::NUM_LANES;       // Round robin fill
            s.lane = r[3:0];
            if (i % 5 != 3) begin
                s.word = random_stub();             // Else a zero word on the lane
            end
            if (i % 5 == 1) begin
                s.word.tag = '0;                    // Payload alone marks a stub
            end else if (i % 5 == 2) begin
                s.word.payload = '0;                // Tag alone marks a stub
            end
        end else if (i < PHASE_C) begin
            r      = (j / 4) % stub_pkg::NUM_LANES;
            s.lane = r[3:0];
            if (j % 4 == 1) begin
                s.word = random_stub();             // Writes between reads
            end
            r         = (j % 10 == 9) ? 32'd63 : j % 10;   // 8 and 63 name no lane
            s.rd_lane = r[io_bus_pkg::LANE_SEL_W-1:0];
            s.sel     = 1'b1;
            s.sync    = 1'b1;
            s.rd_en   = 1'b1;
            if (j % 7 == 6) begin
                case ((j / 7) % 3)                  // One strobe missing
                    0:       s.sel   = 1'b0;
                    1:       s.sync  = 1'b0;
                    default: s.rd_en = 1'b0;
                endcase
            end
            if (int'(s.rd_lane) < stub_pkg::NUM_LANES && model_wptr[int'(s.rd_lane)] > 0) begin
                r = j % model_wptr[int'(s.rd_lane)];   // Only words already written
            end else begin
                r = $urandom();
            end
            s.rd_word = r[stub_pkg::PTR_W-1:0];
        end
        if (i < PHASE_C) begin
            for (int l = 0; l < stub_pkg::NUM_LANES; l++) begin
                if (l == 0 || (i % (l + 2)) != 0) begin
                    r        = $urandom_range(1, 63);
                    s.cnt[l] = r[stub_pkg::RD_ADDR_W-1:0];
                end
            end
        end
    endtask

    task automatic model_step(inout step_t s);
        int l;
        // Read sees the buffer before this row's write
        s.exp_rsp.ack  = s.sel & s.sync & s.rd_en;
        s.exp_rsp.data = '0;
        if (s.exp_rsp.ack && int'(s.rd_lane) < stub_pkg::NUM_LANES) begin
            s.exp_rsp.data = model_mem[int'(s.rd_lane)][s.rd_word];
        end
        l = int'(s.lane);
        if (s.word != '0) begin
            model_mem[l][model_wptr[l] % stub_pkg::BUF_DEPTH] = s.word.payload;  // Stub k+1
            model_wptr[l]++;
        end
        for (int k = 0; k < stub_pkg::NUM_LANES; k++) begin
            if (s.cnt[k] != '0) begin
                model_addr[k] = model_addr[k] + stub_pkg::rd_addr_t'(1);   // 63 wraps to 0
            end
            s.exp_addr[k] = model_addr[k];
        end
    endtask

    task automatic build_table();
        step_t s;
        for (int l = 0; l < stub_pkg::NUM_LANES; l++) begin
            model_wptr[l] = 0;
            model_addr[l] = '1;                     // Counter reset value
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            make_stimulus(i, s);
            model_step(s);
            steps[i] = s;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic apply_row(input step_t s);
        for (int l = 0; l < stub_pkg::NUM_LANES; l++) begin
            if (int'(s.lane) == l) begin
                stub_in[l] = s.word;
            end else begin
                stub_in[l] = '0;
            end
            stub_count[l] = s.cnt[l];
        end
        io_req.sel       = s.sel;
        io_req.sync      = s.sync;
        io_req.rd_en     = s.rd_en;
        io_req.addr.rsvd = '0;
        io_req.addr.lane = s.rd_lane;
        io_req.addr.word = s.rd_word;
    endtask

    initial begin
        lane_cnt_t last_addr;
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        apply_row('0);                              // All inputs quiet
        void'($urandom(SEED));
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("io_rsp.ack", 64'd0, 64'(io_rsp.ack));   // Reset values
        for (int l = 0; l < stub_pkg::NUM_LANES; l++) begin
            check_value($sformatf("read_addr[%0d]", l), 64'h3f, 64'(read_addr[l]));
        end
        rst_n = 1'b1;
        exp_q.push_back('0);                        // Nothing due in the first two cycles
        exp_q.push_back('0);
        last_addr = '1;
        for (int k = 0; k < NUM_ROWS + 2; k++) begin
            @(negedge clk);
            compare_outputs(last_addr);
            if (k < NUM_ROWS) begin
                apply_row(steps[k]);
                exp_q.push_back(steps[k].exp_rsp);
                last_addr = steps[k].exp_addr;
            end else begin
                apply_row('0);                      // Drain the response pipe
                exp_q.push_back('0);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Run length is the table plus some margin
    initial begin
        #(CLK_PERIOD * (NUM_ROWS + 50));
        $display("Timeout: run still going after %0d cycles", NUM_ROWS + 50);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : tb_stub_reader

`default_nettype wire

// ==== design/stub_reader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stub_reader_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire stub_pkg::stub_t     stub_in    [stub_pkg::NUM_LANES],  // One word per lane
    input  wire stub_pkg::rd_addr_t  stub_count [stub_pkg::NUM_LANES],  // Pending per lane
    output stub_pkg::rd_addr_t       read_addr  [stub_pkg::NUM_LANES],
    input  wire io_bus_pkg::io_req_t io_req,
    output io_bus_pkg::io_rsp_t      io_rsp
);

    stub_pkg::ptr_t              rd_ptr;                            // Shared readback index
    logic [stub_pkg::DATA_W-1:0] lane_rd_data [stub_pkg::NUM_LANES]; // Lane read ports

    ////////////////////////////////////////////////////////////
    // Capture lanes
    ////////////////////////////////////////////////////////////

    genvar g;
    for (g = 0; g < stub_pkg::NUM_LANES; g++) begin : g_lane
        stub_capture_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .stub    (stub_in[g]),
            .rd_ptr  (rd_ptr),
            .rd_data (lane_rd_data[g])
        );
    end

    ////////////////////////////////////////////////////////////
    // Read-address counters
    ////////////////////////////////////////////////////////////

    read_address_gen u_rd_addr (
        .clk        (clk),
        .rst_n      (rst_n),
        .stub_count (stub_count),
        .read_addr  (read_addr)
    );

    ////////////////////////////////////////////////////////////
    // Programming-bus readback
    ////////////////////////////////////////////////////////////

    io_readback u_io (
        .clk       (clk),
        .rst_n     (rst_n),
        .io_req    (io_req),
        .rd_ptr    (rd_ptr),
        .lane_data (lane_rd_data),
        .io_rsp    (io_rsp)
    );

endmodule : stub_reader_top

`default_nettype wire

// ==== design/io_readback.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_readback (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire io_bus_pkg::io_req_t         io_req,
    output stub_pkg::ptr_t                   rd_ptr,                         // To every lane
    input  wire logic [stub_pkg::DATA_W-1:0] lane_data [stub_pkg::NUM_LANES], // From the lanes
    output io_bus_pkg::io_rsp_t              io_rsp
);

    ////////////////////////////////////////////////////////////
    // Request decode
    ////////////////////////////////////////////////////////////

    logic                              req_hit;         // Read request this cycle
    logic                              req_d1;          // Request one cycle old
    logic [io_bus_pkg::LANE_SEL_W-1:0] lane_d1;         // Lane select aligned to lane data
    logic [stub_pkg::DATA_W-1:0]       sel_word;        // Mux output, zero for no lane
    logic                              ack_q;
    logic [io_bus_pkg::IO_DATA_W-1:0]  data_q;

    assign req_hit = io_req.sel & io_req.sync & io_req.rd_en;   // All three needed
    assign rd_ptr  = io_req.addr.word;                  // Lanes start their read now

    ////////////////////////////////////////////////////////////
    // Stage 1, wait for the lane read port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_d1 <= 1'b0;
        end else begin
            req_d1 <= req_hit;
        end
    end

    always_ff @(posedge clk) begin
        lane_d1 <= io_req.addr.lane;                    // Select travels with its request
    end

    // Selects of NUM_LANES and above match nothing and read zero
    always_comb begin
        sel_word = '0;
        for (int i = 0; i < stub_pkg::NUM_LANES; i++) begin
            if (int'(lane_d1) == i) begin
                sel_word = lane_data[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, response register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_d1;                            // Two cycles after the request
        end
    end

    always_ff @(posedge clk) begin
        data_q <= sel_word;                             // Only meaningful with ack
    end

    assign io_rsp.ack  = ack_q;
    assign io_rsp.data = data_q;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Every ack belongs to a request two cycles back
    a_ack_src: assert property (
        @(posedge clk) disable iff (!rst_n)
        io_rsp.ack |-> $past(req_hit, 2)
    ) else $error("io_readback: ack without a request two cycles earlier");

endmodule : io_readback

`default_nettype wire

// ==== design/read_address_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_address_gen (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire stub_pkg::rd_addr_t stub_count [stub_pkg::NUM_LANES],  // Pending stubs per lane
    output stub_pkg::rd_addr_t      read_addr  [stub_pkg::NUM_LANES]   // Next fetch address
);

    ////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////

    // All ones at reset, first advance gives address 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < stub_pkg::NUM_LANES; i++) begin
                read_addr[i] <= '1;
            end
        end else begin
            for (int i = 0; i < stub_pkg::NUM_LANES; i++) begin
                if (stub_count[i] != '0) begin
                    read_addr[i] <= read_addr[i] + 1'b1;   // Wraps 63 to 0
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    genvar g;
    for (g = 0; g < stub_pkg::NUM_LANES; g++) begin : g_chk
        // Idle lane keeps its address
        a_hold: assert property (
            @(posedge clk) disable iff (!rst_n)
            (stub_count[g] == '0) |=> $stable(read_addr[g])
        ) else $error("read_address_gen: lane %0d moved with zero count", g);
    end

endmodule : read_address_gen

`default_nettype wire

// ==== design/stub_capture_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module stub_capture_lane (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire stub_pkg::stub_t            stub,       // Nonzero word is a write strobe
    input  wire stub_pkg::ptr_t             rd_ptr,     // Readback word index
    output logic [stub_pkg::DATA_W-1:0]     rd_data     // Word at rd_ptr one cycle later
);

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    logic                        stub_valid;            // Any bit set in the 36-bit word
    stub_pkg::ptr_t              wr_ptr;                // Last written word
    stub_pkg::ptr_t              wr_addr;               // Where the next stub lands
    logic [stub_pkg::DATA_W-1:0] mem [stub_pkg::BUF_DEPTH];

    assign stub_valid = (stub != '0);                   // Tag bits count too
    assign wr_addr    = wr_ptr + 1'b1;                  // Wraps at BUF_DEPTH

    // Pointer starts at all ones so stub 1 goes to word 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '1;
        end else if (stub_valid) begin
            wr_ptr <= wr_addr;                          // Advance on every stub
        end
    end

    // Payload write port
    always_ff @(posedge clk) begin
        if (stub_valid) begin
            mem[wr_addr] <= stub.payload;               // Tag nibble dropped
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    // Registered read returns the old word on a same-cycle collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_ptr];
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Each stub moves the pointer by exactly one word
    a_ptr_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        stub_valid |=> (wr_ptr == stub_pkg::ptr_t'($past(wr_ptr) + 1'b1))
    ) else $error("stub_capture_lane: write pointer did not step by one");

endmodule : stub_capture_lane

`default_nettype wire

// ==== design/io_bus_pkg.sv ====
`default_nettype none

package io_bus_pkg;

    localparam int IO_ADDR_W  = 16;                 // Address bits left after upstream decode
    localparam int IO_DATA_W  = 32;                 // Readback data width
    localparam int LANE_SEL_W = 6;                  // Lane field, wider than the lane count

    // Bits above lane select are not decoded here
    localparam int RSVD_W = IO_ADDR_W - LANE_SEL_W - stub_pkg::PTR_W;

    ////////////////////////////////////////////////////////////
    // Address and bus structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [RSVD_W-1:0]     rsvd;                // Ignored
        logic [LANE_SEL_W-1:0] lane;                // Which capture buffer
        stub_pkg::ptr_t        word;                // Word inside that buffer
    } io_addr_t;

    typedef struct packed {
        logic     sel;                              // Block selected
        logic     sync;                             // Start of access
        logic     rd_en;                            // Read access
        io_addr_t addr;
    } io_req_t;

    typedef struct packed {
        logic                 ack;                  // Data valid this cycle
        logic [IO_DATA_W-1:0] data;
    } io_rsp_t;

endpackage : io_bus_pkg

`default_nettype wire

// ==== design/stub_pkg.sv ====
`default_nettype none

package stub_pkg;

    ////////////////////////////////////////////////////////////
    // Lane count and word widths
    ////////////////////////////////////////////////////////////

    localparam int NUM_LANES = 8;                   // Capture lanes, also counter lanes

    localparam int STUB_W = 36;                     // Full stub word on the link
    localparam int DATA_W = 32;                     // Payload kept in the buffer
    localparam int TAG_W  = STUB_W - DATA_W;        // Upper bits, not stored

    ////////////////////////////////////////////////////////////
    // Capture buffer geometry
    ////////////////////////////////////////////////////////////

    localparam int BUF_DEPTH = 256;                 // Words per lane buffer
    localparam int PTR_W     = 8;                   // log2 of BUF_DEPTH

    // Read-address counters and pending counts share this width
    localparam int RD_ADDR_W = 6;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    // One stub word as it arrives, all zero means no stub
    typedef struct packed {
        logic [TAG_W-1:0]  tag;                     // Top nibble, dropped on capture
        logic [DATA_W-1:0] payload;                 // Low 32 bits, stored
    } stub_t;

    typedef logic [PTR_W-1:0] ptr_t;                // Buffer word address

    typedef logic [RD_ADDR_W-1:0] rd_addr_t;        // Read address or pending count

endpackage : stub_pkg

`default_nettype wire
